// ==== verilog/dzBusPkg.sv ====
// DZ11 register bus definitions
`default_nettype none

package dzBusPkg;

   ////////////////////
   // Bus widths and base address
   ////////////////////

   localparam int dzWordWidth = 16;
   localparam int dzAddrWidth = 18;
   localparam logic [dzAddrWidth-1:0] dzBaseAddr = 18'o760010;

   // Byte offsets from the base
   localparam logic [dzAddrWidth-1:0] csrOffset  = 18'o0;
   localparam logic [dzAddrWidth-1:0] rbufOffset = 18'o2;
   localparam logic [dzAddrWidth-1:0] tcrOffset  = 18'o4;
   localparam logic [dzAddrWidth-1:0] msrOffset  = 18'o6;
   // TDR is the write side of the MSR address
   localparam logic [dzAddrWidth-1:0] tdrOffset  = msrOffset;

   ////////////////////
   // Register layouts
   ////////////////////

   // Control and status
   typedef struct packed {
      logic       trdy;
      logic [3:0] zero14;
      logic [2:0] tline;
      logic       rdone;
      logic       zero6;
      logic       mse;
      logic       clr;
      logic       maint;
      logic [2:0] zero2;
   } dzCsrFields;

   // DTR in high byte, line enables in low byte
   typedef struct packed {
      logic [7:0] dtr;
      logic [7:0] lineEnable;
   } dzTcrFields;

   // Receive buffer
   typedef struct packed {
      logic       valid;
      logic       zero14;
      logic       frameError;
      logic [1:0] zero12;
      logic [2:0] line;
      logic [7:0] rxData;
   } dzRbufFields;

   // One bus word, decoded by whichever register it belongs to
   typedef union packed {
      dzCsrFields             csr;
      dzTcrFields             tcr;
      dzRbufFields            rbuf;
      logic [dzWordWidth-1:0] raw;
   } dzRegWord;

endpackage

`default_nettype wire

// ==== verilog/dzLinePkg.sv ====
// DZ11 serial line definitions
`default_nettype none

package dzLinePkg;

   localparam int dzLines     = 8;
   localparam int dzCharBits  = 8;
   // Start bit, data bits, one stop bit
   localparam int dzFrameBits = dzCharBits + 2;
   localparam int dzBitClocks = 16;
   localparam int dzSiloDepth = 16;
   localparam int dzSiloAddrBits = $clog2(dzSiloDepth);

   typedef logic [2:0] dzLineIndex;

   // Bit time counter and frame bit index
   typedef logic [$clog2(dzBitClocks)-1:0] dzBitTimer;
   typedef logic [$clog2(dzFrameBits)-1:0] dzBitIndex;
   localparam dzBitTimer dzHalfBit = dzBitTimer'(dzBitClocks / 2 - 1);
   localparam dzBitTimer dzFullBit = dzBitTimer'(dzBitClocks - 1);
   localparam dzBitIndex dzStopBit = dzBitIndex'(dzFrameBits - 1);

   // Received character with its tag
   typedef struct packed {
      logic                  frameError;
      dzLineIndex            line;
      logic [dzCharBits-1:0] rxData;
   } dzRxChar;

endpackage

`default_nettype wire

// ==== verilog/dzRegisters.sv ====
// DZ11 register block
`default_nettype none
`timescale 1ns/100ps

module dzRegisters
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic [dzBusPkg::dzAddrWidth-1:0]     busAddr,
   input  logic                                 busRead,
   input  logic                                 busWrite,
   input  dzBusPkg::dzRegWord                   busDataIn,
   input  logic                                 trdy,
   input  dzLinePkg::dzLineIndex                tline,
   input  logic                                 rdone,
   input  dzBusPkg::dzRegWord                   rbufWord,
   input  logic [dzLinePkg::dzLines-1:0]        co,
   input  logic [dzLinePkg::dzLines-1:0]        ri,
   input  logic [dzLinePkg::dzLines-1:0]        txd,
   input  logic [dzLinePkg::dzLines-1:0]        rxd,
   output dzBusPkg::dzRegWord                   busDataOut,
   output logic                                 busAck,
   output logic                                 clear,
   output logic                                 csrMse,
   output logic [dzLinePkg::dzLines-1:0]        lineEnable,
   output logic [dzLinePkg::dzLines-1:0]        dtr,
   output logic                                 tdrWrite,
   output logic [dzLinePkg::dzCharBits-1:0]     tdrChar,
   output logic                                 rbufRead,
   output logic [dzLinePkg::dzLines-1:0]        lineRxd
);

   import dzBusPkg::*;
   import dzLinePkg::*;

   logic csrRead, csrWrite, tcrRead, tcrWrite, msrRead;
   logic csrMaint;
   dzTcrFields tcr;
   // Modem inputs through two flops
   logic [dzLines-1:0] coMeta, coSync, riMeta, riSync;

   ////////////////////
   // Address decode
   ////////////////////

   assign csrRead  = busRead  && busAddr == dzBaseAddr + csrOffset;
   assign csrWrite = busWrite && busAddr == dzBaseAddr + csrOffset;
   assign rbufRead = busRead  && busAddr == dzBaseAddr + rbufOffset;
   assign tcrRead  = busRead  && busAddr == dzBaseAddr + tcrOffset;
   assign tcrWrite = busWrite && busAddr == dzBaseAddr + tcrOffset;
   assign msrRead  = busRead  && busAddr == dzBaseAddr + msrOffset;
   assign tdrWrite = busWrite && busAddr == dzBaseAddr + tdrOffset;

   // No ack for unmapped or write-only-read combinations
   assign busAck = csrRead | csrWrite | rbufRead | tcrRead | tcrWrite | msrRead | tdrWrite;

   // Character goes straight to the selected UART
   assign tdrChar = busDataIn.raw[dzCharBits-1:0];

   ////////////////////
   // CSR and TCR state
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clear    <= 1'b0;
         csrMse   <= 1'b0;
         csrMaint <= 1'b0;
         tcr      <= '0;
      end
      else
      begin
         // One-cycle clear pulse, CLR itself never stored
         clear <= csrWrite && busDataIn.csr.clr;
         if (clear)
         begin
            csrMse   <= 1'b0;
            csrMaint <= 1'b0;
         end
         else if (csrWrite)
         begin
            csrMse   <= busDataIn.csr.mse;
            csrMaint <= busDataIn.csr.maint;
         end
         if (clear)
            tcr <= '0;
         else if (tcrWrite)
            tcr <= busDataIn.tcr;
      end
   end

   assign lineEnable = tcr.lineEnable;
   assign dtr        = tcr.dtr;

   // Carrier and ring sampling
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         coMeta <= '0;
         coSync <= '0;
         riMeta <= '0;
         riSync <= '0;
      end
      else
      begin
         coMeta <= co;
         coSync <= coMeta;
         riMeta <= ri;
         riSync <= riMeta;
      end
   end

   // Maintenance loopback, each line hears its own transmitter
   assign lineRxd = csrMaint ? txd : rxd;

   ////////////////////
   // Read data
   ////////////////////

   always_comb
   begin
      busDataOut = '0;
      if (csrRead)
      begin
         busDataOut.csr.trdy  = trdy;
         busDataOut.csr.tline = tline;
         busDataOut.csr.rdone = rdone;
         busDataOut.csr.mse   = csrMse;
         busDataOut.csr.maint = csrMaint;
      end
      else if (rbufRead)
         busDataOut = rbufWord;
      else if (tcrRead)
         busDataOut.tcr = tcr;
      else if (msrRead)
         busDataOut.raw = {coSync, riSync};
   end

   // Bus master issues one strobe at a time
   assert property (@(posedge clk) disable iff (reset) !(busRead && busWrite));

endmodule

`default_nettype wire

// ==== verilog/dzTransmitScanner.sv ====
// Transmit line scanner
`default_nettype none
`timescale 1ns/100ps

module dzTransmitScanner
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          clear,
   input  logic                          csrMse,
   input  logic [dzLinePkg::dzLines-1:0] lineEnable,
   input  logic [dzLinePkg::dzLines-1:0] txEmpty,
   input  logic                          tdrWrite,
   output logic                          trdy,
   output dzLinePkg::dzLineIndex         tline,
   output logic [dzLinePkg::dzLines-1:0] txLoad
);

   // Scan pointer doubles as TLINE
   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         trdy  <= 1'b0;
         tline <= '0;
      end
      else if (!csrMse)
         trdy <= 1'b0;
      else if (trdy)
      begin
         // Hold the line until software loads it
         if (tdrWrite)
            trdy <= 1'b0;
      end
      else if (lineEnable[tline] && txEmpty[tline])
         trdy <= 1'b1;
      else
         tline <= tline + 1'b1;
   end

   // TDR write becomes a load for the held line only
   always_comb
   begin
      txLoad        = '0;
      txLoad[tline] = tdrWrite && trdy;
   end

   // Loads land on an empty line
   assert property (@(posedge clk) disable iff (reset)
      |txLoad |-> (txLoad & ~txEmpty) == '0);

endmodule

`default_nettype wire

// ==== verilog/dzLineUart.sv ====
// Single line 8N1 UART
`default_nettype none
`timescale 1ns/100ps

module dzLineUart
#(
   parameter dzLinePkg::dzLineIndex lineNumber = '0
)
(
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             clear,
   input  logic                             rxd,
   input  logic                             rxTake,
   input  logic                             txLoad,
   input  logic [dzLinePkg::dzCharBits-1:0] txChar,
   output logic                             txd,
   output logic                             txEmpty,
   output logic                             rxFull,
   output dzLinePkg::dzRxChar               rxChar
);

   import dzLinePkg::*;

   // Transmit side
   logic [dzFrameBits-1:0] txShift;
   dzBitTimer              txTimer;
   dzBitIndex              txBit;

   // Receive side
   logic                  rxMeta, rxSync;
   logic                  rxBusy;
   dzBitTimer             rxTimer;
   dzBitIndex             rxBit;
   logic [dzCharBits-1:0] rxShift;

   ////////////////////
   // Transmitter
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         txShift <= '1;
         txTimer <= '0;
         txBit   <= '0;
         txEmpty <= 1'b1;
      end
      else if (txLoad)
      begin
         // Stop, data, start; LSB goes out first
         txShift <= {1'b1, txChar, 1'b0};
         txTimer <= '0;
         txBit   <= '0;
         txEmpty <= 1'b0;
      end
      else if (!txEmpty)
      begin
         if (txTimer == dzFullBit)
         begin
            txTimer <= '0;
            txShift <= {1'b1, txShift[dzFrameBits-1:1]};
            txBit   <= txBit + 1'b1;
            // End of stop bit
            if (txBit == dzStopBit)
               txEmpty <= 1'b1;
         end
         else
            txTimer <= txTimer + 1'b1;
      end
   end

   // Shifter idles at ones so the line rests high
   assign txd = txShift[0];

   ////////////////////
   // Receiver
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         rxMeta <= 1'b1;
         rxSync <= 1'b1;
      end
      else
      begin
         rxMeta <= rxd;
         rxSync <= rxMeta;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         rxBusy  <= 1'b0;
         rxTimer <= '0;
         rxBit   <= '0;
         rxFull  <= 1'b0;
      end
      else
      begin
         if (rxTake)
            rxFull <= 1'b0;
         if (!rxBusy)
         begin
            // Falling edge, wait half a bit for the start centre
            if (!rxSync)
            begin
               rxBusy  <= 1'b1;
               rxTimer <= dzHalfBit;
               rxBit   <= '0;
            end
         end
         else if (rxTimer != '0)
            rxTimer <= rxTimer - 1'b1;
         else
         begin
            // Mid-bit sample
            rxTimer <= dzFullBit;
            rxBit   <= rxBit + 1'b1;
            if (rxBit == '0)
            begin
               // Glitch, not a start bit
               if (rxSync)
                  rxBusy <= 1'b0;
            end
            else if (rxBit == dzStopBit)
            begin
               // Newest character overwrites an unread one
               rxBusy <= 1'b0;
               rxFull <= 1'b1;
            end
            else
               rxShift <= {rxSync, rxShift[dzCharBits-1:1]};
         end
      end
   end

   // Holding buffer with line tag and framing flag
   always_ff @(posedge clk)
   begin
      if (rxBusy && rxTimer == '0 && rxBit == dzStopBit)
      begin
         rxChar.frameError <= !rxSync;
         rxChar.line       <= lineNumber;
         rxChar.rxData     <= rxShift;
      end
   end

   // Scanner only loads idle transmitters
   assert property (@(posedge clk) disable iff (reset) txLoad |-> txEmpty);

endmodule

`default_nettype wire

// ==== verilog/dzReceiveSilo.sv ====
// Receive scanner and silo FIFO
`default_nettype none
`timescale 1ns/100ps

module dzReceiveSilo
(
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic                                         clear,
   input  logic                                         csrMse,
   input  logic [dzLinePkg::dzLines-1:0]                rxFull,
   input  dzLinePkg::dzRxChar [dzLinePkg::dzLines-1:0]  rxChars,
   input  logic                                         rbufRead,
   output logic [dzLinePkg::dzLines-1:0]                rxTake,
   output logic                                         rdone,
   output dzBusPkg::dzRegWord                           rbufWord
);

   import dzBusPkg::*;
   import dzLinePkg::*;

   dzLineIndex                rxScan;
   dzRxChar                   silo [dzSiloDepth];
   logic [dzSiloAddrBits-1:0] wrPtr, rdPtr;
   logic [dzSiloAddrBits:0]   count;
   logic                      siloFull;
   logic                      push, pop;
   dzRxChar                   head;

   // Depth is a power of two, so the count MSB means full
   assign siloFull = count[dzSiloAddrBits];
   assign rdone    = count != '0;
   assign push     = csrMse && !siloFull && rxFull[rxScan];
   assign pop      = rbufRead && rdone;

   // Take strobe back to the scanned UART
   always_comb
   begin
      rxTake         = '0;
      rxTake[rxScan] = push;
   end

   ////////////////////
   // Scan pointer and FIFO control
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         rxScan <= '0;
         wrPtr  <= '0;
         rdPtr  <= '0;
         count  <= '0;
      end
      else
      begin
         // Stall the scan while full
         if (csrMse && !siloFull)
            rxScan <= rxScan + 1'b1;
         if (push)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
         count <= count + {{dzSiloAddrBits{1'b0}}, push} - {{dzSiloAddrBits{1'b0}}, pop};
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (push)
         silo[wrPtr] <= rxChars[rxScan];
   end

   assign head = silo[rdPtr];

   // RBUF view of the head entry or a zero word when empty
   always_comb
   begin
      rbufWord = '0;
      if (rdone)
      begin
         rbufWord.rbuf.valid      = 1'b1;
         rbufWord.rbuf.frameError = head.frameError;
         rbufWord.rbuf.line       = head.line;
         rbufWord.rbuf.rxData     = head.rxData;
      end
   end

   // Count stays within the depth and matches the pointer distance
   assert property (@(posedge clk) disable iff (reset)
      (count <= dzSiloDepth) && (wrPtr - rdPtr == count[dzSiloAddrBits-1:0]));

endmodule

`default_nettype wire

// ==== verilog/dzMux.sv ====
// DZ11 eight line terminal multiplexer
`default_nettype none
`timescale 1ns/100ps

module dzMux
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [dzBusPkg::dzAddrWidth-1:0]  busAddr,
   input  logic                              busRead,
   input  logic                              busWrite,
   input  dzBusPkg::dzRegWord                busDataIn,
   output dzBusPkg::dzRegWord                busDataOut,
   output logic                              busAck,
   input  logic [dzLinePkg::dzLines-1:0]     rxd,
   input  logic [dzLinePkg::dzLines-1:0]     co,
   input  logic [dzLinePkg::dzLines-1:0]     ri,
   output logic [dzLinePkg::dzLines-1:0]     txd,
   output logic [dzLinePkg::dzLines-1:0]     dtr
);

   import dzBusPkg::*;
   import dzLinePkg::*;

   // Register block outputs
   logic                  clear;
   logic                  csrMse;
   logic [dzLines-1:0]    lineEnable;
   logic                  tdrWrite;
   logic [dzCharBits-1:0] tdrChar;
   logic                  rbufRead;
   logic [dzLines-1:0]    lineRxd;

   // Scanner, line and silo handshakes
   logic                  trdy;
   dzLineIndex            tline;
   logic [dzLines-1:0]    txLoad;
   logic [dzLines-1:0]    txEmpty;
   logic [dzLines-1:0]    rxFull;
   logic [dzLines-1:0]    rxTake;
   dzRxChar [dzLines-1:0] rxChars;
   logic                  rdone;
   dzRegWord              rbufWord;

   dzRegisters dzRegisters_i (
      .clk        (clk),
      .reset      (reset),
      .busAddr    (busAddr),
      .busRead    (busRead),
      .busWrite   (busWrite),
      .busDataIn  (busDataIn),
      .trdy       (trdy),
      .tline      (tline),
      .rdone      (rdone),
      .rbufWord   (rbufWord),
      .co         (co),
      .ri         (ri),
      .txd        (txd),
      .rxd        (rxd),
      .busDataOut (busDataOut),
      .busAck     (busAck),
      .clear      (clear),
      .csrMse     (csrMse),
      .lineEnable (lineEnable),
      .dtr        (dtr),
      .tdrWrite   (tdrWrite),
      .tdrChar    (tdrChar),
      .rbufRead   (rbufRead),
      .lineRxd    (lineRxd)
   );

   dzTransmitScanner dzTransmitScanner_i (
      .clk        (clk),
      .reset      (reset),
      .clear      (clear),
      .csrMse     (csrMse),
      .lineEnable (lineEnable),
      .txEmpty    (txEmpty),
      .tdrWrite   (tdrWrite),
      .trdy       (trdy),
      .tline      (tline),
      .txLoad     (txLoad)
   );

   ////////////////////
   // One UART per line
   ////////////////////

   for (genvar i = 0; i < dzLines; i++)
   begin : lineGen
      dzLineUart #(.lineNumber(dzLineIndex'(i))) dzLineUart_i (
         .clk     (clk),
         .reset   (reset),
         .clear   (clear),
         .rxd     (lineRxd[i]),
         .rxTake  (rxTake[i]),
         .txLoad  (txLoad[i]),
         .txChar  (tdrChar),
         .txd     (txd[i]),
         .txEmpty (txEmpty[i]),
         .rxFull  (rxFull[i]),
         .rxChar  (rxChars[i])
      );
   end

   dzReceiveSilo dzReceiveSilo_i (
      .clk      (clk),
      .reset    (reset),
      .clear    (clear),
      .csrMse   (csrMse),
      .rxFull   (rxFull),
      .rxChars  (rxChars),
      .rbufRead (rbufRead),
      .rxTake   (rxTake),
      .rdone    (rdone),
      .rbufWord (rbufWord)
   );

endmodule

`default_nettype wire

// ==== testbench/dzClockGen.sv ====
// Testbench clock and reset
`default_nettype none
`timescale 1ns/100ps

module dzClockGen
(
   output logic clk,
   output logic reset
);

   // 4 ns period
   localparam int halfPeriod  = 2;
   localparam int resetCycles = 3;

   initial
   begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      // Release on a falling edge, away from the sampling edge
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// ==== testbench/dzMuxTb.sv ====
// DZ11 multiplexer directed testbench
`default_nettype none
`timescale 1ns/100ps

module dzMuxTb;

   import dzBusPkg::*;
   import dzLinePkg::*;

   localparam logic [dzAddrWidth-1:0] csrAddr  = dzBaseAddr + csrOffset;
   localparam logic [dzAddrWidth-1:0] rbufAddr = dzBaseAddr + rbufOffset;
   localparam logic [dzAddrWidth-1:0] tcrAddr  = dzBaseAddr + tcrOffset;
   localparam logic [dzAddrWidth-1:0] msrAddr  = dzBaseAddr + msrOffset;
   localparam logic [dzAddrWidth-1:0] tdrAddr  = dzBaseAddr + tdrOffset;
   // First address past the register window
   localparam logic [dzAddrWidth-1:0] holeAddr = dzBaseAddr + 18'o10;

   // Poll and frame limits
   localparam int pollLimit  = 400;
   localparam int frameLimit = 20 * dzBitClocks;
   localparam int waitTrdy   = 0;
   localparam int waitRdone  = 1;
   localparam int waitIdle   = 2;

   logic                   clk;
   logic                   reset;
   logic [dzAddrWidth-1:0] busAddr;
   logic                   busRead;
   logic                   busWrite;
   dzRegWord               busDataIn;
   dzRegWord               busDataOut;
   logic                   busAck;
   logic [dzLines-1:0]     rxd;
   logic [dzLines-1:0]     co;
   logic [dzLines-1:0]     ri;
   logic [dzLines-1:0]     txd;
   logic [dzLines-1:0]     dtr;

   int     errorCount;
   int     testStartErrors;
   int     testsRun;
   int     testsFailed;
   integer seed;

   dzClockGen dzClockGen_i (
      .clk   (clk),
      .reset (reset)
   );

   dzMux dzMux_i (
      .clk        (clk),
      .reset      (reset),
      .busAddr    (busAddr),
      .busRead    (busRead),
      .busWrite   (busWrite),
      .busDataIn  (busDataIn),
      .busDataOut (busDataOut),
      .busAck     (busAck),
      .rxd        (rxd),
      .co         (co),
      .ri         (ri),
      .txd        (txd),
      .dtr        (dtr)
   );

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic compareWord(input string name, input dzRegWord got, input dzRegWord exp);
      if (got.raw !== exp.raw)
      begin
         $display("ERR %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
         errorCount++;
      end
   endtask

   task automatic compareLine(input string name, input logic [dzLines-1:0] got,
                              input logic [dzLines-1:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         errorCount++;
      end
   endtask

   task automatic compareChar(input string name, input logic [dzCharBits-1:0] got,
                              input logic [dzCharBits-1:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         errorCount++;
      end
   endtask

   ////////////////////
   // Bus accesses
   ////////////////////

   // One-cycle strobe with data sampled mid-cycle
   task automatic busReadReg(input logic [dzAddrWidth-1:0] addr, input string name,
                             output dzRegWord data);
      @(negedge clk);
      busAddr = addr;
      busRead = 1'b1;
      #1;
      data = busDataOut;
      if (busAck !== 1'b1)
      begin
         $display("no bus acknowledge when reading %s at %0t", name, $time);
         errorCount++;
      end
      @(negedge clk);
      busRead = 1'b0;
   endtask

   task automatic busWriteReg(input logic [dzAddrWidth-1:0] addr, input string name,
                              input dzRegWord data);
      @(negedge clk);
      busAddr   = addr;
      busDataIn = data;
      busWrite  = 1'b1;
      #1;
      if (busAck !== 1'b1)
      begin
         $display("no bus acknowledge when writing %s at %0t", name, $time);
         errorCount++;
      end
      @(negedge clk);
      busWrite = 1'b0;
   endtask

   // Unmapped read must stay silent
   task automatic probeUnmapped();
      @(negedge clk);
      busAddr = holeAddr;
      busRead = 1'b1;
      #1;
      if (busAck !== 1'b0)
      begin
         $display("bus acknowledge seen for an unmapped address at %0t", $time);
         errorCount++;
      end
      @(negedge clk);
      busRead = 1'b0;
   endtask

   // Read CSR until a condition holds
   task automatic pollCsr(input int cond, input string what, output dzRegWord csr);
      int   tries;
      logic met;
      tries = 0;
      met   = 1'b0;
      csr   = '0;
      while (!met && tries < pollLimit)
      begin
         busReadReg(csrAddr, "CSR", csr);
         case (cond)
            waitTrdy:  met = csr.csr.trdy;
            waitRdone: met = csr.csr.rdone;
            default:   met = !csr.csr.rdone;
         endcase
         tries++;
      end
      if (!met)
      begin
         $display("timed out waiting for %s", what);
         errorCount++;
      end
   endtask

   ////////////////////
   // Serial line helpers
   ////////////////////

   // 8N1 frame sent LSB first
   task automatic sendSerial(input dzLineIndex line, input logic [dzCharBits-1:0] data);
      logic [dzFrameBits-1:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < dzFrameBits; i++)
      begin
         @(negedge clk);
         rxd[line] = frame[i];
         repeat (dzBitClocks - 1) @(negedge clk);
      end
   endtask

   task automatic captureSerial(input dzLineIndex line, output logic [dzCharBits-1:0] data,
                                output logic ok);
      int waitCount;
      waitCount = 0;
      ok        = 1'b0;
      data      = '0;
      @(negedge clk);
      while (txd[line] !== 1'b0 && waitCount < frameLimit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (txd[line] !== 1'b0)
         $display("no start bit seen on txd line %0d", line);
      else
      begin
         // Centre of the start bit
         repeat (dzBitClocks / 2) @(negedge clk);
         for (int i = 0; i < dzCharBits; i++)
         begin
            repeat (dzBitClocks) @(negedge clk);
            data[i] = txd[line];
         end
         repeat (dzBitClocks) @(negedge clk);
         if (txd[line] !== 1'b1)
            $display("bad stop bit on txd line %0d", line);
         else
            ok = 1'b1;
      end
      if (!ok)
         errorCount++;
   endtask

   function automatic logic [dzCharBits-1:0] randomChar();
      int value;
      value = $random(seed);
      return value[dzCharBits-1:0];
   endfunction

   task automatic beginTest();
      testStartErrors = errorCount;
      testsRun++;
   endtask

   task automatic endTest(input int number, input string name);
      if (errorCount == testStartErrors)
         $display("test %0d %s: passed", number, name);
      else
      begin
         $display("test %0d %s: failed", number, name);
         testsFailed++;
      end
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic checkResetState();
      dzRegWord got;
      beginTest();
      busReadReg(csrAddr, "CSR", got);
      compareWord("CSR", got, '0);
      busReadReg(tcrAddr, "TCR", got);
      compareWord("TCR", got, '0);
      busReadReg(rbufAddr, "RBUF", got);
      compareWord("RBUF", got, '0);
      busReadReg(msrAddr, "MSR", got);
      compareWord("MSR", got, '0);
      compareLine("dtr", dtr, '0);
      compareLine("txd", txd, '1);
      probeUnmapped();
      endTest(1, "reset state");
   endtask

   task automatic checkModemStatus();
      dzRegWord got;
      dzRegWord exp;
      int       tries;
      beginTest();
      @(negedge clk);
      co = 8'ha5;
      ri = 8'h3c;
      // Carrier in the high byte, ring in the low byte
      exp.raw = {8'ha5, 8'h3c};
      tries   = 0;
      busReadReg(msrAddr, "MSR", got);
      while (got.raw !== exp.raw && tries < pollLimit)
      begin
         busReadReg(msrAddr, "MSR", got);
         tries++;
      end
      compareWord("MSR", got, exp);
      endTest(2, "modem status");
   endtask

   task automatic checkTransmit();
      dzRegWord              word;
      dzRegWord              exp;
      logic [dzCharBits-1:0] sent;
      logic [dzCharBits-1:0] seen;
      logic                  ok;
      beginTest();
      word            = '0;
      word.tcr.dtr    = 8'h01 << 3;
      word.tcr.lineEnable = 8'h01 << 3;
      busWriteReg(tcrAddr, "TCR", word);
      compareLine("dtr", dtr, word.tcr.dtr);
      word         = '0;
      word.csr.mse = 1'b1;
      busWriteReg(csrAddr, "CSR", word);
      pollCsr(waitTrdy, "TRDY", word);
      exp           = '0;
      exp.csr.trdy  = 1'b1;
      exp.csr.tline = 3'd3;
      exp.csr.mse   = 1'b1;
      compareWord("CSR", word, exp);
      sent     = randomChar();
      word     = '0;
      word.raw = {8'h00, sent};
      busWriteReg(tdrAddr, "TDR", word);
      captureSerial(3'd3, seen, ok);
      compareChar("txd[3] character", seen, sent);
      endTest(3, "transmit line 3");
   endtask

   task automatic checkReceive();
      dzRegWord              got;
      dzRegWord              exp;
      logic [dzCharBits-1:0] sent;
      beginTest();
      sent = randomChar();
      sendSerial(3'd5, sent);
      pollCsr(waitRdone, "RDONE", got);
      exp             = '0;
      exp.rbuf.valid  = 1'b1;
      exp.rbuf.line   = 3'd5;
      exp.rbuf.rxData = sent;
      busReadReg(rbufAddr, "RBUF", got);
      compareWord("RBUF", got, exp);
      // Silo now drained
      busReadReg(rbufAddr, "RBUF", got);
      compareWord("RBUF", got, '0);
      endTest(4, "receive line 5");
   endtask

   task automatic checkLoopback();
      dzRegWord              word;
      dzRegWord              exp;
      logic [dzCharBits-1:0] sent;
      beginTest();
      // Drop MSE first so TRDY lets go of line 3
      busWriteReg(csrAddr, "CSR", '0);
      word                = '0;
      word.tcr.lineEnable = 8'h01 << 2;
      busWriteReg(tcrAddr, "TCR", word);
      word           = '0;
      word.csr.mse   = 1'b1;
      word.csr.maint = 1'b1;
      busWriteReg(csrAddr, "CSR", word);
      pollCsr(waitTrdy, "TRDY", word);
      exp           = '0;
      exp.csr.trdy  = 1'b1;
      exp.csr.tline = 3'd2;
      exp.csr.mse   = 1'b1;
      exp.csr.maint = 1'b1;
      compareWord("CSR", word, exp);
      sent     = randomChar();
      word     = '0;
      word.raw = {8'h00, sent};
      busWriteReg(tdrAddr, "TDR", word);
      // Character comes back through the transmitter while rxd idles
      pollCsr(waitRdone, "RDONE", word);
      exp             = '0;
      exp.rbuf.valid  = 1'b1;
      exp.rbuf.line   = 3'd2;
      exp.rbuf.rxData = sent;
      busReadReg(rbufAddr, "RBUF", word);
      compareWord("RBUF", word, exp);
      // Only line 2 heard its own transmitter
      busReadReg(rbufAddr, "RBUF", word);
      compareWord("RBUF", word, '0);
      endTest(5, "maintenance loopback");
   endtask

   task automatic checkClear();
      dzRegWord word;
      beginTest();
      word         = '0;
      word.csr.mse = 1'b1;
      busWriteReg(csrAddr, "CSR", word);
      word            = '0;
      word.tcr.dtr    = 8'hc3;
      busWriteReg(tcrAddr, "TCR", word);
      sendSerial(3'd6, randomChar());
      pollCsr(waitRdone, "RDONE", word);
      word         = '0;
      word.csr.clr = 1'b1;
      busWriteReg(csrAddr, "CSR", word);
      // Clear empties the silo, so RDONE falling marks its arrival
      pollCsr(waitIdle, "RDONE to clear", word);
      compareWord("CSR", word, '0);
      busReadReg(tcrAddr, "TCR", word);
      compareWord("TCR", word, '0);
      busReadReg(rbufAddr, "RBUF", word);
      compareWord("RBUF", word, '0);
      compareLine("dtr", dtr, '0);
      endTest(6, "master clear");
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      int resetWait;
      busAddr     = '0;
      busRead     = 1'b0;
      busWrite    = 1'b0;
      busDataIn   = '0;
      rxd         = '1;
      co          = '0;
      ri          = '0;
      errorCount  = 0;
      testsRun    = 0;
      testsFailed = 0;
      seed        = 32'h4166bc04;
      resetWait   = 0;
      @(negedge clk);
      while (reset && resetWait < 20)
      begin
         @(negedge clk);
         resetWait++;
      end
      if (reset)
      begin
         $display("reset never released");
         errorCount++;
      end
      checkResetState();
      checkModemStatus();
      checkTransmit();
      checkReceive();
      checkLoopback();
      checkClear();
      $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
               errorCount);
      if (errorCount == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/dzBusPkg.sv
verilog/dzLinePkg.sv
verilog/dzRegisters.sv
verilog/dzTransmitScanner.sv
verilog/dzLineUart.sv
verilog/dzReceiveSilo.sv
verilog/dzMux.sv
testbench/dzClockGen.sv
testbench/dzMuxTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the DZ11 testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module dzMuxTb -o dzMuxTbSim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dzMuxTbSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
